/* hw/cnn_weight_pkg.sv */
`default_nettype none

package cnn_weight_pkg;

  localparam int TAP_W         = 8;
  localparam int KERNEL_TAPS   = 9;
  localparam int WORD_W        = TAP_W * KERNEL_TAPS;  // One 3x3 kernel per word.
  localparam int WORDS_PER_SET = 4;
  localparam int VEC_W         = WORD_W * WORDS_PER_SET;

  localparam int LAYER_STRIDE = 32;
  localparam int PHASE_STRIDE = 4;
  localparam int RAM_DEPTH    = 160;
  localparam int ADDR_W       = 8;

  // Codes 5 to 7 are illegal.
  typedef enum logic [2:0] {
    LAYER0 = 3'd0,
    LAYER1 = 3'd1,
    LAYER2 = 3'd2,
    LAYER3 = 3'd3,
    AFFINE = 3'd4
  } layer_sel_t;

  // Register byte offsets.
  localparam logic [7:0] REG_WDATA0 = 8'h00;
  localparam logic [7:0] REG_WDATA1 = 8'h04;
  localparam logic [7:0] REG_WDATA2 = 8'h08;
  localparam logic [7:0] REG_WADDR  = 8'h0C;  // Write commits the staged word.
  localparam logic [7:0] REG_CTRL   = 8'h10;
  localparam logic [7:0] REG_STATUS = 8'h14;

endpackage

`default_nettype wire

/* hw/weight_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module weight_ram #(
  parameter int RAM_DEPTH = cnn_weight_pkg::RAM_DEPTH
) (
  input  wire logic                                clk,
  input  wire logic                                we,
  input  wire logic [cnn_weight_pkg::ADDR_W-1:0]   waddr,
  input  wire logic [cnn_weight_pkg::WORD_W-1:0]   wdata,
  input  wire logic [cnn_weight_pkg::ADDR_W-1:0]   raddr,
  output logic      [cnn_weight_pkg::WORD_W-1:0]   rdata
);

  logic [cnn_weight_pkg::WORD_W-1:0] mem [RAM_DEPTH];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
    rdata <= mem[raddr];  // Data one cycle after the address.
  end

  // Host must stay inside the array.
  a_waddr_range: assert property (@(posedge clk) we |-> int'(waddr) < RAM_DEPTH)
    else $error("weight_ram: write address %0d beyond depth %0d", waddr, RAM_DEPTH);

endmodule

`default_nettype wire

/* hw/weight_store.sv */
`timescale 1ns/1ps
`default_nettype none

module weight_store (
  input  wire logic                                clk,
  input  wire logic                                rst_n,
  input  wire logic                                load,
  input  wire cnn_weight_pkg::layer_sel_t          layer,
  input  wire logic [2:0]                          phase,
  output logic      [cnn_weight_pkg::ADDR_W-1:0]   raddr,
  input  wire logic [cnn_weight_pkg::WORD_W-1:0]   rdata,
  output logic                                     valid,
  output logic      [cnn_weight_pkg::VEC_W-1:0]    vec
);

  localparam int AW     = cnn_weight_pkg::ADDR_W;
  localparam int WW     = cnn_weight_pkg::WORD_W;
  localparam int NWORDS = cnn_weight_pkg::WORDS_PER_SET;
  localparam int SLOT_W = $clog2(NWORDS);
  localparam int CNT_W  = $clog2(NWORDS + 2);

  logic [AW-1:0]     offset;
  logic              active;
  logic [CNT_W-1:0]  cnt;
  logic [SLOT_W-1:0] slot;

  assign offset = AW'(cnn_weight_pkg::LAYER_STRIDE * int'(layer)
                    + cnn_weight_pkg::PHASE_STRIDE * int'(phase));

  // Word k returns one cycle after its address, so it lands at cnt k+1.
  assign slot = SLOT_W'(cnt - CNT_W'(1));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      active <= 1'b0;
      cnt    <= '0;
      valid  <= 1'b0;
      raddr  <= '0;
      vec    <= '0;
    end else if (!load) begin
      active <= 1'b0;
      cnt    <= '0;
      valid  <= 1'b0;
      raddr  <= offset;
    end else if (!active) begin
      // Base taken on the first load edge and held till load drops.
      active <= 1'b1;
      cnt    <= '0;
      raddr  <= offset;
    end else begin
      if (cnt < CNT_W'(NWORDS - 1)) begin
        raddr <= raddr + 1'b1;
      end
      if (cnt >= CNT_W'(1) && cnt <= CNT_W'(NWORDS)) begin
        vec[slot*WW +: WW] <= rdata;
      end
      if (cnt == CNT_W'(NWORDS + 1)) begin
        valid <= 1'b1;  // All four slots filled.
      end else begin
        cnt <= cnt + 1'b1;
      end
    end
  end

  a_valid_drop: assert property (@(posedge clk) disable iff (!rst_n)
    !$past(load) |-> !valid)
    else $error("weight_store: valid high after load low");

  // The register block refuses codes above AFFINE.
  a_layer_legal: assert property (@(posedge clk) disable iff (!rst_n)
    load |-> layer <= cnn_weight_pkg::AFFINE)
    else $error("weight_store: illegal layer code %0d", layer);

endmodule

`default_nettype wire

/* hw/weight_cfg_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module weight_cfg_regs #(
  parameter int AXI_ADDR_W = 8
) (
  input  wire logic                                clk,
  input  wire logic                                rst_n,
  input  wire logic [AXI_ADDR_W-1:0]               awaddr,
  input  wire logic                                awvalid,
  output logic                                     awready,
  input  wire logic [31:0]                         wdata,
  input  wire logic [3:0]                          wstrb,
  input  wire logic                                wvalid,
  output logic                                     wready,
  output logic      [1:0]                          bresp,
  output logic                                     bvalid,
  input  wire logic                                bready,
  input  wire logic [AXI_ADDR_W-1:0]               araddr,
  input  wire logic                                arvalid,
  output logic                                     arready,
  output logic      [31:0]                         rdata,
  output logic      [1:0]                          rresp,
  output logic                                     rvalid,
  input  wire logic                                rready,
  input  wire logic                                store_valid,
  output logic                                     ram_we,
  output logic      [cnn_weight_pkg::ADDR_W-1:0]   ram_waddr,
  output logic      [cnn_weight_pkg::WORD_W-1:0]   ram_wdata,
  output cnn_weight_pkg::layer_sel_t               layer,
  output logic      [2:0]                          phase,
  output logic                                     load
);

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  localparam logic [AXI_ADDR_W-1:0] A_WDATA0 = AXI_ADDR_W'(cnn_weight_pkg::REG_WDATA0);
  localparam logic [AXI_ADDR_W-1:0] A_WDATA1 = AXI_ADDR_W'(cnn_weight_pkg::REG_WDATA1);
  localparam logic [AXI_ADDR_W-1:0] A_WDATA2 = AXI_ADDR_W'(cnn_weight_pkg::REG_WDATA2);
  localparam logic [AXI_ADDR_W-1:0] A_WADDR  = AXI_ADDR_W'(cnn_weight_pkg::REG_WADDR);
  localparam logic [AXI_ADDR_W-1:0] A_CTRL   = AXI_ADDR_W'(cnn_weight_pkg::REG_CTRL);
  localparam logic [AXI_ADDR_W-1:0] A_STATUS = AXI_ADDR_W'(cnn_weight_pkg::REG_STATUS);

  logic                             wr_rdy;
  logic                             rd_rdy;
  logic                             wr_pend;
  logic                             wr_fire;
  logic                             rd_fire;
  logic                             idle;
  logic                             ctrl_ok;
  logic [1:0]                       wr_resp;
  logic [31:0]                      stage0;
  logic [31:0]                      stage1;
  logic [cnn_weight_pkg::TAP_W-1:0] stage2;

  function automatic logic [31:0] merge_bytes(input logic [31:0] cur,
                                              input logic [31:0] nxt,
                                              input logic [3:0]  strb);
    logic [31:0] res;
    res = cur;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) begin
        res[i*8 +: 8] = nxt[i*8 +: 8];
      end
    end
    return res;
  endfunction

  assign awready   = wr_rdy;  // Address and data taken together.
  assign wready    = wr_rdy;
  assign arready   = rd_rdy;
  assign rresp     = RESP_OKAY;
  assign wr_fire   = wr_rdy && awvalid && wvalid;
  assign rd_fire   = rd_rdy && arvalid;
  assign idle      = !(wr_rdy || rd_rdy || wr_pend || bvalid || rvalid);
  assign ctrl_ok   = wdata[2:0] <= cnn_weight_pkg::AFFINE;
  assign ram_wdata = {stage2, stage1, stage0};

  always_comb begin
    case (awaddr)
      A_WDATA0, A_WDATA1, A_WDATA2, A_WADDR: wr_resp = RESP_OKAY;
      A_CTRL:  wr_resp = ctrl_ok ? RESP_OKAY : RESP_SLVERR;
      default: wr_resp = RESP_SLVERR;  // STATUS is read-only.
    endcase
  end

  // One transaction at a time. Writes win a tie.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_rdy  <= 1'b0;
      rd_rdy  <= 1'b0;
      wr_pend <= 1'b0;
      bvalid  <= 1'b0;
      rvalid  <= 1'b0;
    end else begin
      wr_rdy  <= idle && awvalid && wvalid;
      rd_rdy  <= idle && arvalid && !(awvalid && wvalid);
      wr_pend <= wr_fire;
      if (wr_pend) begin
        bvalid <= 1'b1;
      end else if (bready) begin
        bvalid <= 1'b0;
      end
      if (rd_fire) begin
        rvalid <= 1'b1;
      end else if (rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      layer  <= cnn_weight_pkg::LAYER0;
      phase  <= '0;
      load   <= 1'b0;
      ram_we <= 1'b0;
    end else begin
      ram_we <= wr_fire && awaddr == A_WADDR;  // Commit pulse.
      if (wr_fire && awaddr == A_CTRL && ctrl_ok) begin
        layer <= cnn_weight_pkg::layer_sel_t'(wdata[2:0]);
        phase <= wdata[6:4];
        load  <= wdata[8];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_fire) begin
      bresp <= wr_resp;
      case (awaddr)
        A_WDATA0: stage0 <= merge_bytes(stage0, wdata, wstrb);
        A_WDATA1: stage1 <= merge_bytes(stage1, wdata, wstrb);
        A_WDATA2: begin
          if (wstrb[0]) begin
            stage2 <= wdata[cnn_weight_pkg::TAP_W-1:0];
          end
        end
        A_WADDR:  ram_waddr <= wdata[cnn_weight_pkg::ADDR_W-1:0];
        default:  ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rd_fire) begin
      case (araddr)
        A_WDATA0: rdata <= stage0;
        A_WDATA1: rdata <= stage1;
        A_WDATA2: rdata <= 32'(stage2);
        A_WADDR:  rdata <= 32'(ram_waddr);
        A_CTRL:   rdata <= {23'd0, load, 1'b0, phase, 1'b0, layer};
        A_STATUS: rdata <= {31'd0, store_valid};
        default:  rdata <= '0;
      endcase
    end
  end

  a_bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
    bvalid && !bready |=> bvalid)
    else $error("weight_cfg_regs: bvalid dropped before bready");

endmodule

`default_nettype wire

/* hw/weight_subsystem_top.sv */
`timescale 1ns/1ps
`default_nettype none

module weight_subsystem_top #(
  parameter int AXI_ADDR_W = 8,
  parameter int RAM_DEPTH  = cnn_weight_pkg::RAM_DEPTH
) (
  input  wire logic                                clk,
  input  wire logic                                rst_n,
  input  wire logic [AXI_ADDR_W-1:0]               awaddr,
  input  wire logic                                awvalid,
  output logic                                     awready,
  input  wire logic [31:0]                         wdata,
  input  wire logic [3:0]                          wstrb,
  input  wire logic                                wvalid,
  output logic                                     wready,
  output logic      [1:0]                          bresp,
  output logic                                     bvalid,
  input  wire logic                                bready,
  input  wire logic [AXI_ADDR_W-1:0]               araddr,
  input  wire logic                                arvalid,
  output logic                                     arready,
  output logic      [31:0]                         rdata,
  output logic      [1:0]                          rresp,
  output logic                                     rvalid,
  input  wire logic                                rready,
  output logic                                     valid,
  output logic      [cnn_weight_pkg::VEC_W-1:0]    vec
);

  logic                              ram_we;
  logic [cnn_weight_pkg::ADDR_W-1:0] ram_waddr;
  logic [cnn_weight_pkg::WORD_W-1:0] ram_wdata;
  logic [cnn_weight_pkg::ADDR_W-1:0] ram_raddr;
  logic [cnn_weight_pkg::WORD_W-1:0] ram_rdata;
  cnn_weight_pkg::layer_sel_t        layer;
  logic [2:0]                        phase;
  logic                              load;

  weight_cfg_regs #(
    .AXI_ADDR_W (AXI_ADDR_W)
  ) u_regs (
    .clk         (clk),
    .rst_n       (rst_n),
    .awaddr      (awaddr),
    .awvalid     (awvalid),
    .awready     (awready),
    .wdata       (wdata),
    .wstrb       (wstrb),
    .wvalid      (wvalid),
    .wready      (wready),
    .bresp       (bresp),
    .bvalid      (bvalid),
    .bready      (bready),
    .araddr      (araddr),
    .arvalid     (arvalid),
    .arready     (arready),
    .rdata       (rdata),
    .rresp       (rresp),
    .rvalid      (rvalid),
    .rready      (rready),
    .store_valid (valid),
    .ram_we      (ram_we),
    .ram_waddr   (ram_waddr),
    .ram_wdata   (ram_wdata),
    .layer       (layer),
    .phase       (phase),
    .load        (load)
  );

  weight_ram #(
    .RAM_DEPTH (RAM_DEPTH)
  ) u_ram (
    .clk   (clk),
    .we    (ram_we),
    .waddr (ram_waddr),
    .wdata (ram_wdata),
    .raddr (ram_raddr),
    .rdata (ram_rdata)
  );

  weight_store u_store (
    .clk   (clk),
    .rst_n (rst_n),
    .load  (load),
    .layer (layer),
    .phase (phase),
    .raddr (ram_raddr),
    .rdata (ram_rdata),
    .valid (valid),
    .vec   (vec)
  );

endmodule

`default_nettype wire

/* testbench/tb_weight_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_weight_subsystem;

  localparam int LIMIT   = 100;  // Cycles allowed per wait.
  localparam int N_ENTRY = 12;
  localparam int WW      = cnn_weight_pkg::WORD_W;
  localparam logic [1:0] OKAY   = 2'b00;
  localparam logic [1:0] SLVERR = 2'b10;

  typedef struct packed {
    logic [2:0] layer;
    logic [2:0] phase;
    logic [1:0] resp;
    logic       want_vec;
  } entry_t;

  // Layer, phase, CTRL write response, vector expected.
  localparam entry_t ENTRIES [N_ENTRY] = '{
    '{3'd0, 3'd0, OKAY,   1'b1},
    '{3'd1, 3'd3, OKAY,   1'b1},
    '{3'd2, 3'd7, OKAY,   1'b1},
    '{3'd3, 3'd5, OKAY,   1'b1},
    '{3'd4, 3'd7, OKAY,   1'b1},
    '{3'd5, 3'd2, SLVERR, 1'b1},  // Falls back to layer 4 phase 7.
    '{3'd1, 3'd1, OKAY,   1'b1},
    '{3'd7, 3'd0, SLVERR, 1'b0},
    '{3'd4, 3'd0, OKAY,   1'b1},
    '{3'd0, 3'd7, OKAY,   1'b1},
    '{3'd2, 3'd2, OKAY,   1'b1},
    '{3'd3, 3'd0, OKAY,   1'b1}
  };

  logic        clk;
  logic        rst_n;
  logic [7:0]  awaddr;
  logic [7:0]  araddr;
  logic [31:0] wdata;
  logic [31:0] rdata;
  logic [3:0]  wstrb;
  logic [1:0]  bresp;
  logic [1:0]  rresp;
  logic        awvalid;
  logic        awready;
  logic        wvalid;
  logic        wready;
  logic        bvalid;
  logic        bready;
  logic        arvalid;
  logic        arready;
  logic        rvalid;
  logic        rready;
  logic        valid;
  logic [cnn_weight_pkg::VEC_W-1:0] vec;

  logic [WW-1:0] model [cnn_weight_pkg::RAM_DEPTH];
  int            errors;
  int            timeouts;
  logic [2:0]    cur_layer;
  logic [2:0]    cur_phase;
  logic [1:0]    resp;
  logic [31:0]   rd;

  weight_subsystem_top #(
    .AXI_ADDR_W (8),
    .RAM_DEPTH  (cnn_weight_pkg::RAM_DEPTH)
  ) u_dut (.*);

  initial clk = 1'b0;
  always #4 clk = ~clk;

  // Layer in bits 2:0, phase in 6:4, load in bit 8.
  function automatic logic [31:0] ctrl_word(input logic [2:0] layer, input logic [2:0] phase,
                                            input logic load);
    return 32'(layer) | (32'(phase) << 4) | (32'(load) << 8);
  endfunction

  task automatic timeout_hit(input string what);
    $display("Timeout waiting for %s at %0t", what, $time);
    timeouts++;
  endtask

  task automatic expect_word(input logic [31:0] got, input logic [31:0] exp, input string what);
    assert (got === exp) else begin
      errors++;
      $display("[FAIL] %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic axi_write(input logic [7:0] addr, input logic [31:0] data, input int hold,
                           output logic [1:0] got);
    int cnt;
    got = 2'b11;
    if (timeouts != 0) return;
    awaddr  = addr;
    wdata   = data;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    bready  = (hold == 0);
    cnt = 0;
    @(negedge clk);
    while (!(awready && wready) && cnt < LIMIT) begin
      @(negedge clk);
      cnt++;
    end
    if (!(awready && wready)) timeout_hit("awready and wready");
    @(posedge clk);
    #1;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    cnt = 0;
    @(negedge clk);
    while (!bvalid && cnt < LIMIT) begin
      @(negedge clk);
      cnt++;
    end
    if (!bvalid) timeout_hit("bvalid");
    got = bresp;
    if (hold > 0) begin
      repeat (hold) begin
        @(negedge clk);
        assert (bvalid) else begin
          errors++;
          $display("bvalid dropped while bready was still low at %0t", $time);
        end
      end
      @(posedge clk);
      #1;
      bready = 1'b1;
    end
    @(posedge clk);
    #1;
    bready = 1'b0;
  endtask

  task automatic axi_read(input logic [7:0] addr, output logic [31:0] data,
                          output logic [1:0] got);
    int cnt;
    data = '0;
    got  = 2'b11;
    if (timeouts != 0) return;
    araddr  = addr;
    arvalid = 1'b1;
    cnt = 0;
    @(negedge clk);
    while (!arready && cnt < LIMIT) begin
      @(negedge clk);
      cnt++;
    end
    if (!arready) timeout_hit("arready");
    @(posedge clk);
    #1;
    arvalid = 1'b0;
    rready  = 1'b1;
    cnt = 0;
    @(negedge clk);
    while (!rvalid && cnt < LIMIT) begin
      @(negedge clk);
      cnt++;
    end
    if (!rvalid) timeout_hit("rvalid");
    data = rdata;
    got  = rresp;
    @(posedge clk);
    #1;
    rready = 1'b0;
  endtask

  task automatic write_ok(input logic [7:0] addr, input logic [31:0] data);
    axi_write(addr, data, 0, resp);
    expect_word(32'(resp), 32'(OKAY), "write response");
  endtask

  // Stage the word in three registers, then commit it.
  task automatic write_word(input int addr, input logic [WW-1:0] word);
    write_ok(cnn_weight_pkg::REG_WDATA0, word[31:0]);
    write_ok(cnn_weight_pkg::REG_WDATA1, word[63:32]);
    write_ok(cnn_weight_pkg::REG_WDATA2, 32'(word[71:64]));
    write_ok(cnn_weight_pkg::REG_WADDR, 32'(addr));
  endtask

  task automatic wait_valid(input logic level);
    int cnt;
    if (timeouts != 0) return;
    cnt = 0;
    @(negedge clk);
    while (valid !== level && cnt < LIMIT) begin
      @(negedge clk);
      cnt++;
    end
    if (valid !== level) timeout_hit("valid to settle");
    @(posedge clk);
    #1;
  endtask

  task automatic check_vector(input logic [2:0] layer, input logic [2:0] phase);
    logic [cnn_weight_pkg::VEC_W-1:0] exp;
    int base;
    base = int'(layer) * cnn_weight_pkg::LAYER_STRIDE + int'(phase) * cnn_weight_pkg::PHASE_STRIDE;
    for (int k = 0; k < cnn_weight_pkg::WORDS_PER_SET; k++) begin
      exp[k*WW +: WW] = model[base + k];  // Word k in slot k.
    end
    wait_valid(1'b1);
    assert (vec === exp) else begin
      errors++;
      $display("[FAIL] %0t: vec for layer %0d phase %0d got %h expected %h",
               $time, layer, phase, vec, exp);
    end
    axi_read(cnn_weight_pkg::REG_STATUS, rd, resp);
    expect_word(rd, 32'd1, "STATUS with vector ready");
  endtask

  task automatic run_entry(input entry_t e);
    write_ok(cnn_weight_pkg::REG_CTRL, ctrl_word(cur_layer, cur_phase, 1'b0));
    wait_valid(1'b0);
    axi_read(cnn_weight_pkg::REG_STATUS, rd, resp);
    expect_word(rd, 32'd0, "STATUS after load low");
    axi_write(cnn_weight_pkg::REG_CTRL, ctrl_word(e.layer, e.phase, 1'b1), 0, resp);
    expect_word(32'(resp), 32'(e.resp), "CTRL load response");
    if (e.resp == SLVERR) begin
      axi_read(cnn_weight_pkg::REG_CTRL, rd, resp);
      expect_word(rd, ctrl_word(cur_layer, cur_phase, 1'b0), "CTRL after refused layer");
      if (e.want_vec) begin
        write_ok(cnn_weight_pkg::REG_CTRL, ctrl_word(cur_layer, cur_phase, 1'b1));
      end
    end else begin
      cur_layer = e.layer;
      cur_phase = e.phase;
    end
    if (e.want_vec) begin
      check_vector(cur_layer, cur_phase);
    end else begin
      repeat (8) @(negedge clk);
      expect_word(32'(valid), 32'd0, "valid without load");
      @(posedge clk);
      #1;
    end
  endtask

  initial begin
    logic [WW-1:0] word;
    logic [cnn_weight_pkg::VEC_W-1:0] old_vec;
    int addr;
    errors    = 0;
    timeouts  = 0;
    cur_layer = 3'd0;
    cur_phase = 3'd0;
    void'($urandom(32'h100b_be67));
    rst_n   = 1'b0;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = 4'hF;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    assert (!valid && !bvalid && !rvalid && vec == '0) else begin
      errors++;
      $display("[FAIL] %0t: outputs not cleared by reset", $time);
    end

    for (int a = 0; a < cnn_weight_pkg::RAM_DEPTH; a++) begin
      for (int t = 0; t < cnn_weight_pkg::KERNEL_TAPS; t++) begin
        word[t*8 +: 8] = 8'($urandom);
      end
      model[a] = word;
      write_word(a, word);
    end

    for (int i = 0; i < N_ENTRY; i++) begin
      if (timeouts != 0) break;
      run_entry(ENTRIES[i]);
    end

    // Rewrite word 2 of the current set.
    addr = int'(cur_layer) * cnn_weight_pkg::LAYER_STRIDE
         + int'(cur_phase) * cnn_weight_pkg::PHASE_STRIDE + 2;
    for (int k = 0; k < cnn_weight_pkg::WORDS_PER_SET; k++) begin
      old_vec[k*WW +: WW] = model[addr - 2 + k];  // Set as written before the rewrite.
    end
    model[addr] = ~model[addr];
    write_word(addr, model[addr]);
    write_ok(cnn_weight_pkg::REG_CTRL, ctrl_word(cur_layer, cur_phase, 1'b0));
    wait_valid(1'b0);
    write_ok(cnn_weight_pkg::REG_CTRL, ctrl_word(cur_layer, cur_phase, 1'b1));
    check_vector(cur_layer, cur_phase);
    for (int k = 0; k < cnn_weight_pkg::WORDS_PER_SET; k++) begin
      expect_word(32'(vec[k*WW +: WW] !== old_vec[k*WW +: WW]), 32'(k == 2), "slot changed");
    end

    axi_write(cnn_weight_pkg::REG_STATUS, 32'd1, 0, resp);
    expect_word(32'(resp), 32'(SLVERR), "STATUS write response");
    axi_write(8'h20, 32'h0000_00A5, 0, resp);
    expect_word(32'(resp), 32'(SLVERR), "unmapped write response");
    axi_read(8'h3C, rd, resp);
    expect_word(rd, 32'd0, "unmapped read data");
    expect_word(32'(resp), 32'(OKAY), "unmapped read response");

    // Load issued with bready held low.
    write_ok(cnn_weight_pkg::REG_CTRL, ctrl_word(cur_layer, cur_phase, 1'b0));
    wait_valid(1'b0);
    axi_write(cnn_weight_pkg::REG_CTRL, ctrl_word(3'd1, 3'd6, 1'b1), 6, resp);
    expect_word(32'(resp), 32'(OKAY), "stalled CTRL response");
    cur_layer = 3'd1;
    cur_phase = 3'd6;
    check_vector(cur_layer, cur_phase);

    $display("Errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
hw/cnn_weight_pkg.sv
hw/weight_ram.sv
hw/weight_store.sv
hw/weight_cfg_regs.sv
hw/weight_subsystem_top.sv
testbench/tb_weight_subsystem.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the weight subsystem testbench with Verilator.
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f project.f \
  --top-module tb_weight_subsystem -o tb_weight_subsystem \
  && ./obj_dir/tb_weight_subsystem | tee sim.log \
  || { echo "Build or simulation error"; exit 1; }
grep -q "Test failed" sim.log && exit 1 || exit 0
